// File: src.f
+incdir+include
rtl/rpPkg.sv
rtl/rpRegDecode.sv
rtl/rpCylAddr.sv
rtl/rpTrkSecAddr.sv
rtl/rpDrive.sv
rtl/rpReadMux.sv
rtl/rpDriveBank.sv
testbench/rpDriveBankTb.sv

// File: testbench/rpDriveBankTb.sv
/* Table-driven testbench for the drive bank. With 4 drives on a 2-bit select every
   drive number exists, so out-of-range drive rows have no encoding here */
`default_nettype none
`timescale 1ns/1ns

`include "rp_macros.svh"

module rpDriveBankTb
   import rpPkg::*;
;

   localparam int opWrite   = 0;
   localparam int opRead    = 1;
   localparam int opReady   = 2;
   localparam int opWait    = 3;
   localparam int maxRows   = 128;
   localparam int waitLimit = 4 * `RP_SEEK_CYCLES;

   logic                          clk;
   logic                          rstN;
   logic                          wrStrobe;
   logic [`RP_DRV_BITS-1:0]       wrDrv;
   rpRegSel_t                     wrReg;
   rpData_t                       wrData;
   logic [`RP_DRV_BITS-1:0]       rdDrv;
   rpRegSel_t                     rdReg;
   rpReg_t                        rdData;
   logic [`RP_NUM_DRIVES-1:0]     drvReady;

   // Stimulus table, one row per step
   int                            opTab [maxRows];
   int                            drvTab [maxRows];
   rpRegSel_t                     regTab [maxRows];
   rpData_t                       dataTab [maxRows];
   rpReg_t                        expTab [maxRows];
   int                            rowCount;
   int                            errors;
   int                            checks;
   int                            seed;

   rpDriveBank u_dut (
      .clk      (clk),
      .rstN     (rstN),
      .wrStrobe (wrStrobe),
      .wrDrv    (wrDrv),
      .wrReg    (wrReg),
      .wrData   (wrData),
      .rdDrv    (rdDrv),
      .rdReg    (rdReg),
      .rdData   (rdData),
      .drvReady (drvReady)
   );

   // 20 ns clock
   initial
   begin
      clk = 1'b0;
      forever
         #10 clk = ~clk;
   end

   //////////////////////////////////////////////////////////////////////
   // Table helpers
   //////////////////////////////////////////////////////////////////////
   task automatic addRow(input int op, input int drv, input rpRegSel_t sel,
                         input rpData_t data, input rpReg_t exp);
      opTab[rowCount]   = op;
      drvTab[rowCount]  = drv;
      regTab[rowCount]  = sel;
      dataTab[rowCount] = data;
      expTab[rowCount]  = exp;
      rowCount++;
   endtask

   // CS1 word from function code and GO
   function automatic rpData_t cs1Word(input logic [4:0] func, input logic go);
      rpData_t w;
      w = '0;
      w[`RP_CS1_FUNC_HI:`RP_CS1_FUNC_LO] = func;
      w[`RP_CS1_GO] = go;
      return w;
   endfunction

   task automatic buildTable();
      rpData_t randData;
      int      d;
      int      k;
      // Reset state, ready set in CS1
      for (d = 0; d < `RP_NUM_DRIVES; d++)
      begin
         addRow(opRead, d, regCs1, '0, 16'h0080);
         addRow(opRead, d, regDa, '0, 16'h0000);
         addRow(opRead, d, regDc, '0, 16'h0000);
         addRow(opReady, d, regCs1, '0, 16'h0001);
      end
      // DC keeps 10 bits, DA keeps track and sector fields
      addRow(opWrite, 0, regDc, 36'h1_2345_6789, '0);
      addRow(opRead, 0, regDc, '0, 16'h0389);
      addRow(opWrite, 0, regDa, 36'hA_BCDE_E305, '0);
      addRow(opRead, 0, regDa, '0, 16'h0305);
      // SEEK, then writes while positioning are lost
      addRow(opWrite, 0, regCs1, cs1Word(funcSeek, 1'b1), '0);
      addRow(opReady, 0, regCs1, '0, 16'h0000);
      addRow(opRead, 0, regCs1, '0, 16'h0000);
      addRow(opWrite, 0, regDc, 36'h155, '0);
      addRow(opWrite, 0, regDa, 36'h0102, '0);
      addRow(opRead, 0, regDc, '0, 16'h0389);
      addRow(opRead, 0, regDa, '0, 16'h0305);
      addRow(opWait, 0, regCs1, '0, '0);
      addRow(opWrite, 0, regDc, 36'h2AA, '0);
      addRow(opRead, 0, regDc, '0, 16'h02AA);
      // PRESET keeps ready, RECAL drops it
      addRow(opWrite, 0, regDa, 36'h0A07, '0);
      addRow(opRead, 0, regDa, '0, 16'h0A07);
      addRow(opWrite, 0, regCs1, cs1Word(funcPreset, 1'b1), '0);
      addRow(opReady, 0, regCs1, '0, 16'h0001);
      addRow(opRead, 0, regDc, '0, 16'h0000);
      addRow(opRead, 0, regDa, '0, 16'h0000);
      addRow(opWrite, 0, regDc, 36'h123, '0);
      addRow(opWrite, 0, regDa, 36'h0203, '0);
      addRow(opWrite, 0, regCs1, cs1Word(funcRecal, 1'b1), '0);
      addRow(opReady, 0, regCs1, '0, 16'h0000);
      addRow(opRead, 0, regDc, '0, 16'h0000);
      addRow(opRead, 0, regDa, '0, 16'h0000);
      addRow(opWait, 0, regCs1, '0, '0);
      addRow(opRead, 0, regCs1, '0, 16'h0080);
      // ADVANCE on drive 1: sector step, track wrap, cylinder carry
      addRow(opWrite, 1, regDa, 36'h0005, '0);
      addRow(opWrite, 1, regCs1, cs1Word(funcAdvance, 1'b1), '0);
      addRow(opRead, 1, regDa, '0, 16'h0006);
      addRow(opWrite, 1, regDa, 36'h0313, '0);
      addRow(opWrite, 1, regCs1, cs1Word(funcAdvance, 1'b1), '0);
      addRow(opRead, 1, regDa, '0, 16'h0400);
      addRow(opWrite, 1, regDc, 36'h007, '0);
      addRow(opWrite, 1, regDa, 36'h1213, '0);
      addRow(opWrite, 1, regCs1, cs1Word(funcAdvance, 1'b1), '0);
      addRow(opRead, 1, regDa, '0, 16'h0000);
      addRow(opRead, 1, regDc, '0, 16'h0008);
      addRow(opWrite, 1, regDc, 36'h3FF, '0);
      addRow(opWrite, 1, regDa, 36'h1213, '0);
      addRow(opWrite, 1, regCs1, cs1Word(funcAdvance, 1'b1), '0);
      addRow(opRead, 1, regDa, '0, 16'h0000);
      addRow(opRead, 1, regDc, '0, 16'h0000);
      // Drives independent
      addRow(opWrite, 0, regDc, 36'h042, '0);
      addRow(opWrite, 2, regDc, 36'h155, '0);
      addRow(opRead, 2, regDc, '0, 16'h0155);
      addRow(opRead, 0, regDc, '0, 16'h0042);
      // Random cylinders on drive 3
      for (k = 0; k < 3; k++)
      begin
         randData = rpData_t'($random(seed));
         addRow(opWrite, 3, regDc, randData, '0);
         addRow(opRead, 3, regDc, '0, randData[15:0] & 16'h03FF);
      end
      // No GO, NOP, unknown code
      addRow(opWrite, 2, regCs1, cs1Word(funcSeek, 1'b0), '0);
      addRow(opReady, 2, regCs1, '0, 16'h0001);
      addRow(opWrite, 2, regCs1, cs1Word(funcPreset, 1'b0), '0);
      addRow(opRead, 2, regDc, '0, 16'h0155);
      addRow(opWrite, 2, regCs1, cs1Word(funcNop, 1'b1), '0);
      addRow(opWrite, 2, regCs1, cs1Word(5'd5, 1'b1), '0);
      addRow(opReady, 2, regCs1, '0, 16'h0001);
      addRow(opRead, 2, regDc, '0, 16'h0155);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Compare tasks
   //////////////////////////////////////////////////////////////////////
   task automatic checkReg(input rpReg_t got, input rpReg_t exp, input string what);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("FAILED %0t: %s read %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic checkReady(input logic got, input logic exp, input int drv);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("FAILED %0t: drive %0d ready %b, expected %b", $time, drv, got, exp);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Row execution
   //////////////////////////////////////////////////////////////////////
   task automatic applyRow(input int r);
      int cycles;
      case (opTab[r])
         opWrite:
         begin
            @(negedge clk);
            wrStrobe = 1'b1;
            wrDrv    = drvTab[r][`RP_DRV_BITS-1:0];
            wrReg    = regTab[r];
            wrData   = dataTab[r];
            @(negedge clk);
            wrStrobe = 1'b0;
         end
         opRead:
         begin
            @(negedge clk);
            rdDrv = drvTab[r][`RP_DRV_BITS-1:0];
            rdReg = regTab[r];
            // Sample mid low phase
            #5;
            checkReg(rdData, expTab[r],
                     $sformatf("row %0d drive %0d %s", r, drvTab[r], regTab[r].name()));
         end
         opReady:
         begin
            @(negedge clk);
            #5;
            checkReady(drvReady[drvTab[r]], expTab[r][0], drvTab[r]);
         end
         default:
         begin
            cycles = 0;
            // Poll ready once per clock
            while (!drvReady[drvTab[r]] && cycles < waitLimit)
            begin
               @(negedge clk);
               cycles++;
            end
            if (!drvReady[drvTab[r]])
            begin
               errors++;
               $display("Drive %0d never became ready within %0d cycles at row %0d",
                        drvTab[r], waitLimit, r);
            end
         end
      endcase
   endtask

   initial
   begin
      int r;
      errors   = 0;
      checks   = 0;
      rowCount = 0;
      seed     = 25640;
      rstN     = 1'b0;
      wrStrobe = 1'b0;
      wrDrv    = '0;
      wrReg    = regCs1;
      wrData   = '0;
      rdDrv    = '0;
      rdReg    = regCs1;
      buildTable();
      // Reset for two clocks
      repeat (2) @(posedge clk);
      @(negedge clk);
      rstN = 1'b1;
      for (r = 0; r < rowCount; r++)
         applyRow(r);
      $display("Rows %0d, checks %0d, errors %0d", rowCount, checks, errors);
      if (errors == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

`default_nettype wire

// File: rtl/rpDriveBank.sv
/* Bank of RP_NUM_DRIVES register sets. A write lands at the edge after the one
   that samples the strobe; reads are combinational */
`default_nettype none
`timescale 1ns/1ns

`include "rp_macros.svh"

module rpDriveBank
   import rpPkg::*;
(
   input  wire logic                      clk,
   input  wire logic                      rstN,
   input  wire logic                      wrStrobe,
   input  wire logic [`RP_DRV_BITS-1:0]   wrDrv,
   input  wire rpRegSel_t                 wrReg,
   input  wire rpData_t                   wrData,
   input  wire logic [`RP_DRV_BITS-1:0]   rdDrv,
   input  wire rpRegSel_t                 rdReg,
   output rpReg_t                         rdData,
   output logic [`RP_NUM_DRIVES-1:0]      drvReady
);

   localparam int regBits = $bits(rpReg_t);

   rpData_t                                  wrDataQ;
   logic [`RP_NUM_DRIVES-1:0]                dcWrite;
   logic [`RP_NUM_DRIVES-1:0]                daWrite;
   logic [`RP_NUM_DRIVES-1:0]                preset;
   logic [`RP_NUM_DRIVES-1:0]                recal;
   logic [`RP_NUM_DRIVES-1:0]                seek;
   logic [`RP_NUM_DRIVES-1:0]                advance;
   logic [`RP_NUM_DRIVES*regBits-1:0]        dcAll;
   logic [`RP_NUM_DRIVES*regBits-1:0]        daAll;

   // Host write decode
   rpRegDecode uRegDecode (
      .clk      (clk),
      .rstN     (rstN),
      .wrStrobe (wrStrobe),
      .wrDrv    (wrDrv),
      .wrReg    (wrReg),
      .wrData   (wrData),
      .wrDataQ  (wrDataQ),
      .dcWrite  (dcWrite),
      .daWrite  (daWrite),
      .preset   (preset),
      .recal    (recal),
      .seek     (seek),
      .advance  (advance)
   );

   //////////////////////////////////////////////////////////////////////
   // Drives
   //////////////////////////////////////////////////////////////////////
   for (genvar i = 0; i < `RP_NUM_DRIVES; i++)
   begin : gDrive
      rpDrive uDrive (
         .clk     (clk),
         .rstN    (rstN),
         .wrData  (wrDataQ),
         .dcWrite (dcWrite[i]),
         .daWrite (daWrite[i]),
         .preset  (preset[i]),
         .recal   (recal[i]),
         .seek    (seek[i]),
         .advance (advance[i]),
         .dc      (dcAll[i*regBits +: regBits]),
         .da      (daAll[i*regBits +: regBits]),
         .ready   (drvReady[i])
      );
   end

   // Host read select
   rpReadMux uReadMux (
      .rdDrv    (rdDrv),
      .rdReg    (rdReg),
      .dcAll    (dcAll),
      .daAll    (daAll),
      .readyAll (drvReady),
      .rdData   (rdData)
   );

endmodule

`default_nettype wire

// File: rtl/rpReadMux.sv
/* Combinational read select. A missing drive or an unused register reads 0 */
`default_nettype none
`timescale 1ns/1ns

`include "rp_macros.svh"

module rpReadMux
   import rpPkg::*;
(
   input  wire logic [`RP_DRV_BITS-1:0]                      rdDrv,
   input  wire rpRegSel_t                                    rdReg,
   input  wire logic [`RP_NUM_DRIVES*$bits(rpReg_t)-1:0]     dcAll,
   input  wire logic [`RP_NUM_DRIVES*$bits(rpReg_t)-1:0]     daAll,
   input  wire logic [`RP_NUM_DRIVES-1:0]                    readyAll,
   output rpReg_t                                            rdData
);

   localparam int regBits = $bits(rpReg_t);

   always_comb
   begin
      rdData = '0;
      // Drive must exist
      if (int'(rdDrv) < `RP_NUM_DRIVES)
      begin
         case (rdReg)
            // Status word holds only ready
            regCs1:  rdData[`RP_CS1_RDY] = readyAll[rdDrv];
            regDa:   rdData = daAll[rdDrv*regBits +: regBits];
            regDc:   rdData = dcAll[rdDrv*regBits +: regBits];
            default: rdData = '0;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: rtl/rpDrive.sv
/* One drive. SEEK or RECAL holds ready low for RP_SEEK_CYCLES clocks;
   a new SEEK during positioning restarts the timer */
`default_nettype none
`timescale 1ns/1ns

`include "rp_macros.svh"

module rpDrive
   import rpPkg::*;
(
   input  wire logic     clk,
   input  wire logic     rstN,
   input  wire rpData_t  wrData,
   input  wire logic     dcWrite,
   input  wire logic     daWrite,
   input  wire logic     preset,
   input  wire logic     recal,
   input  wire logic     seek,
   input  wire logic     advance,
   output rpReg_t        dc,
   output rpReg_t        da,
   output logic          ready
);

   localparam int timerBits = $clog2(`RP_SEEK_CYCLES + 1);

   logic [timerBits-1:0]  timer;
   logic                  clearAddr;
   logic                  cylCarry;

   //////////////////////////////////////////////////////////////////////
   // Positioning timer
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk)
   begin
      if (!rstN)
         timer <= '0;
      else if (seek || recal)
         timer <= timerBits'(`RP_SEEK_CYCLES);
      else if (timer != '0)
         timer <= timer - 1'b1;
   end

   // Ready whenever the heads are not moving
   assign ready = (timer == '0);

   // Both functions zero the address
   assign clearAddr = preset || recal;

   //////////////////////////////////////////////////////////////////////
   // Address registers
   //////////////////////////////////////////////////////////////////////
   rpCylAddr uCylAddr (
      .clk    (clk),
      .rstN   (rstN),
      .wrData (wrData),
      .clear  (clearAddr),
      .load   (dcWrite),
      .inc    (cylCarry),
      .ready  (ready),
      .dc     (dc)
   );

   // Track/sector wrap steps the cylinder
   rpTrkSecAddr uTrkSecAddr (
      .clk      (clk),
      .rstN     (rstN),
      .wrData   (wrData),
      .clear    (clearAddr),
      .load     (daWrite),
      .advance  (advance),
      .ready    (ready),
      .da       (da),
      .cylCarry (cylCarry)
   );

endmodule

`default_nettype wire

// File: rtl/rpTrkSecAddr.sv
/* Desired track and sector. Out-of-range loads are kept as written;
   cylCarry is combinational and only valid in the advancing cycle */
`default_nettype none
`timescale 1ns/1ns

`include "rp_macros.svh"

module rpTrkSecAddr
   import rpPkg::*;
(
   input  wire logic     clk,
   input  wire logic     rstN,
   input  wire rpData_t  wrData,
   input  wire logic     clear,
   input  wire logic     load,
   input  wire logic     advance,
   input  wire logic     ready,
   output rpReg_t        da,
   output logic          cylCarry
);

   logic [`RP_DA_TRK_HI:`RP_DA_TRK_LO]  trk;
   logic [`RP_DA_SEC_HI:`RP_DA_SEC_LO]  sec;
   logic                                step;
   logic                                secWrap;
   logic                                trkWrap;

   // Advance ignored while positioning
   assign step    = advance && ready && !clear;
   // Last sector of a track
   assign secWrap = (sec == `RP_SECTORS - 1);
   // Last track of a cylinder
   assign trkWrap = (trk == `RP_TRACKS - 1);

   // Step off the end of the cylinder
   assign cylCarry = step && secWrap && trkWrap;

   //////////////////////////////////////////////////////////////////////
   // Address register
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk)
   begin
      if (!rstN || clear)
      begin
         trk <= '0;
         sec <= '0;
      end
      else if (load && ready)
      begin
         trk <= wrData[`RP_DA_TRK_HI:`RP_DA_TRK_LO];
         sec <= wrData[`RP_DA_SEC_HI:`RP_DA_SEC_LO];
      end
      else if (step)
      begin
         if (secWrap)
         begin
            sec <= '0;
            // Next track, or back to track zero
            trk <= trkWrap ? '0 : trk + 1'b1;
         end
         else
            sec <= sec + 1'b1;
      end
   end

   // Fields placed as in the DA register
   always_comb
   begin
      da = '0;
      da[`RP_DA_TRK_HI:`RP_DA_TRK_LO] = trk;
      da[`RP_DA_SEC_HI:`RP_DA_SEC_LO] = sec;
   end

endmodule

`default_nettype wire

// File: rtl/rpCylAddr.sv
/* Desired cylinder. Clear wins, a load needs ready, an increment wraps at 1024 */
`default_nettype none
`timescale 1ns/1ns

`include "rp_macros.svh"

module rpCylAddr
   import rpPkg::*;
(
   input  wire logic     clk,
   input  wire logic     rstN,
   input  wire rpData_t  wrData,
   input  wire logic     clear,
   input  wire logic     load,
   input  wire logic     inc,
   input  wire logic     ready,
   output rpReg_t        dc
);

   rpCyl_t cyl;

   // Clear first
   // Loads ignored while positioning
   always_ff @(posedge clk)
   begin
      if (!rstN || clear)
         cyl <= '0;
      else if (load && ready)
         cyl <= wrData[`RP_DC_CYL_HI:`RP_DC_CYL_LO];
      else if (inc)
         cyl <= cyl + 1'b1;   // carry from track/sector
   end

   // Upper bits read as zero
   assign dc = rpReg_t'(cyl);

endmodule

`default_nettype wire

// File: rtl/rpRegDecode.sv
/* Host writes land one clock later as per-drive pulses and wrDataQ.
   Out-of-range drives and CS1 writes without GO produce no pulse */
`default_nettype none
`timescale 1ns/1ns

`include "rp_macros.svh"

module rpRegDecode
   import rpPkg::*;
(
   input  wire logic                      clk,
   input  wire logic                      rstN,
   input  wire logic                      wrStrobe,
   input  wire logic [`RP_DRV_BITS-1:0]   wrDrv,
   input  wire rpRegSel_t                 wrReg,
   input  wire rpData_t                   wrData,
   output rpData_t                        wrDataQ,
   output logic [`RP_NUM_DRIVES-1:0]      dcWrite,
   output logic [`RP_NUM_DRIVES-1:0]      daWrite,
   output logic [`RP_NUM_DRIVES-1:0]      preset,
   output logic [`RP_NUM_DRIVES-1:0]      recal,
   output logic [`RP_NUM_DRIVES-1:0]      seek,
   output logic [`RP_NUM_DRIVES-1:0]      advance
);

   logic                       drvValid;
   logic [`RP_NUM_DRIVES-1:0]  drvHot;
   logic                       csGo;
   logic [4:0]                 funcCode;

   // Only drive numbers that exist
   assign drvValid = (int'(wrDrv) < `RP_NUM_DRIVES);

   // One-hot drive select, empty when no strobe
   always_comb
   begin
      drvHot = '0;
      if (wrStrobe && drvValid)
         drvHot[wrDrv] = 1'b1;
   end

   // CS1 function field
   assign funcCode = wrData[`RP_CS1_FUNC_HI:`RP_CS1_FUNC_LO];
   // Functions act only with GO
   assign csGo     = (wrReg == regCs1) && wrData[`RP_CS1_GO];

   //////////////////////////////////////////////////////////////////////
   // Pulse registers
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk)
   begin
      if (!rstN)
      begin
         dcWrite <= '0;
         daWrite <= '0;
         preset  <= '0;
         recal   <= '0;
         seek    <= '0;
         advance <= '0;
      end
      else
      begin
         dcWrite <= (wrReg == regDc) ? drvHot : '0;
         daWrite <= (wrReg == regDa) ? drvHot : '0;
         // NOP and unknown codes fall through to no pulse
         preset  <= (csGo && funcCode == funcPreset)  ? drvHot : '0;
         recal   <= (csGo && funcCode == funcRecal)   ? drvHot : '0;
         seek    <= (csGo && funcCode == funcSeek)    ? drvHot : '0;
         advance <= (csGo && funcCode == funcAdvance) ? drvHot : '0;
      end
   end

   // Write data held for the drives
   always_ff @(posedge clk)
   begin
      if (wrStrobe)
         wrDataQ <= wrData;
   end

endmodule

`default_nettype wire

// File: rtl/rpPkg.sv
/* Shared types of the RP drive bank. Function codes follow the RH CS1 field;
   ADVANCE borrows the read-data code and only steps the sector address */
`default_nettype none

package rpPkg;

   // Host write word, as wide as the processor word
   typedef logic [35:0] rpData_t;

   // Register read value
   typedef logic [15:0] rpReg_t;

   // Desired cylinder
   typedef logic [9:0] rpCyl_t;

   // CS1 function codes, bits 5:1 of the written word
   typedef enum logic [4:0] {
      funcNop     = 5'd0,
      funcSeek    = 5'd2,
      funcRecal   = 5'd3,
      funcPreset  = 5'd8,
      funcAdvance = 5'd28
   } rpFunc_t;

   // Register select on the host bus
   typedef enum logic [1:0] {
      regCs1 = 2'd0,
      regDa  = 2'd1,
      regDc  = 2'd2
   } rpRegSel_t;

endpackage

`default_nettype wire

// File: include/rp_macros.svh
/* Bank size, pack geometry, positioning time and register field positions.
   RP_DRV_BITS must be wide enough to address RP_NUM_DRIVES drives */
`ifndef RP_MACROS_SVH
`define RP_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Bank size
//////////////////////////////////////////////////////////////////////
`define RP_NUM_DRIVES   4
`define RP_DRV_BITS     2

// Pack geometry, counts start at zero
`define RP_SECTORS      20
`define RP_TRACKS       19

// Clocks of ready low after SEEK or RECAL
`define RP_SEEK_CYCLES  8

//////////////////////////////////////////////////////////////////////
// Register field positions
//////////////////////////////////////////////////////////////////////
// CS1
`define RP_CS1_GO       0
`define RP_CS1_FUNC_HI  5
`define RP_CS1_FUNC_LO  1
`define RP_CS1_RDY      7

// DA
`define RP_DA_TRK_HI    12
`define RP_DA_TRK_LO    8
`define RP_DA_SEC_HI    4
`define RP_DA_SEC_LO    0

// DC
`define RP_DC_CYL_HI    9
`define RP_DC_CYL_LO    0

`endif
